// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_serial_io
RTL_TOP   ?= serial_io_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation FAILED, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
+incdir+src
src/serial_io_pkg.sv
src/byte_fifo.sv
src/periph_regs.sv
src/uart_tx.sv
src/uart_rx.sv
src/serial_io_top.sv
testbench/tb_serial_io.sv

// ==== src/byte_fifo.sv ====
// Synchronous byte FIFO
// Occupancy counter gives full/empty, push while full is dropped
`timescale 1ns/1ps
`include "serial_io_settings.svh"

module byte_fifo #(
   parameter int DEPTH = `SIO_FIFO_DEPTH
) (
   input  logic       app_clk_i,
   input  logic       rst_n_i,
   input  logic       push_i,      // Write strobe
   input  logic [7:0] wr_data_i,
   input  logic       pop_i,       // Read strobe
   output logic [7:0] rd_data_o,   // Head entry, no latency
   output logic       full_o,
   output logic       empty_o,
   output logic       drop_o       // Push lost this cycle
);

   localparam int AW = $clog2(DEPTH);

   logic [7:0]    mem [DEPTH];
   logic [AW-1:0] wr_ptr_q;
   logic [AW-1:0] rd_ptr_q;
   logic [AW:0]   count_q;        // One bit wider than pointers
   logic          do_push;
   logic          do_pop;

   assign full_o  = (count_q == (AW+1)'(DEPTH));
   assign empty_o = (count_q == '0);

   // A pop in the same cycle frees the slot, so a full FIFO still takes the push
   assign do_pop  = pop_i & ~empty_o;
   assign do_push = push_i & (~full_o | pop_i);
   assign drop_o  = push_i & full_o & ~pop_i;

   assign rd_data_o = mem[rd_ptr_q];

   // Storage
   always_ff @(posedge app_clk_i) begin
      if (do_push)
         mem[wr_ptr_q] <= wr_data_i;
   end

   always_ff @(posedge app_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push)
            wr_ptr_q <= (wr_ptr_q == AW'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;  // Wrap
         if (do_pop)
            rd_ptr_q <= (rd_ptr_q == AW'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;  // Both or neither
         endcase
      end
   end

endmodule

// ==== src/periph_regs.sv ====
// Register bus decoder for the serial peripheral
// Control, baud, status, GPIO and FIFO data ports, one-cycle ack
`timescale 1ns/1ps
`include "serial_io_settings.svh"

module periph_regs import serial_io_pkg::*; (
   input  logic                  app_clk_i,
   input  logic                  rst_n_i,
   // Register bus
   input  logic                  reg_cs_i,
   input  logic                  reg_wr_i,
   input  logic [3:0]            reg_addr_i,
   input  logic [31:0]           reg_wdata_i,
   output logic [31:0]           reg_rdata_o,
   output logic                  reg_ack_o,
   // Transmit FIFO side
   output logic                  tx_push_o,
   output logic [7:0]            tx_data_o,
   input  logic                  tx_full_i,
   input  logic                  tx_empty_i,
   // Receive FIFO side
   output logic                  rx_pop_o,
   input  logic [7:0]            rx_data_i,
   input  logic                  rx_empty_i,
   input  logic                  rx_drop_i,
   // Control out
   output logic                  tx_en_o,
   output logic                  rx_en_o,
   output logic [`SIO_DIV_W-1:0] baud_div_o,
   output logic [1:0]            gpio_out_o,
   output logic [1:0]            gpio_oe_o,
   input  logic [1:0]            gpio_in_i
);

   reg_addr_e   addr;
   logic        acc_start;     // First cycle of cs
   logic        wr_ack;        // Write commits in ack cycle
   logic        rd_ack;
   logic        overrun_q;     // Sticky rx drop
   logic [31:0] rdata_mux;

   assign addr      = reg_addr_e'(reg_addr_i);
   assign acc_start = reg_cs_i & ~reg_ack_o;
   assign wr_ack    = reg_ack_o & reg_cs_i & reg_wr_i;
   assign rd_ack    = reg_ack_o & reg_cs_i & ~reg_wr_i;

   // Head byte already latched into rdata, pop it now
   assign rx_pop_o = rd_ack & (addr == REG_RXDATA);

   //////////////////////////////////////////////////
   // Read mux
   //////////////////////////////////////////////////
   always_comb begin
      case (addr)
         REG_CTRL:     rdata_mux = {30'h0, rx_en_o, tx_en_o};
         REG_BAUD:     rdata_mux = {{(32-`SIO_DIV_W){1'b0}}, baud_div_o};
         REG_STATUS:   rdata_mux = {28'h0, overrun_q, rx_empty_i, tx_empty_i, tx_full_i};
         REG_RXDATA:   rdata_mux = {24'h0, rx_data_i};
         REG_GPIO_OUT: rdata_mux = {28'h0, gpio_oe_o, gpio_out_o};
         REG_GPIO_IN:  rdata_mux = {30'h0, gpio_in_i};
         default:      rdata_mux = 32'h0;  // TXDATA and holes
      endcase
   end

   // Ack pulse, one cycle per access
   always_ff @(posedge app_clk_i or negedge rst_n_i) begin
      if (!rst_n_i)
         reg_ack_o <= 1'b0;
      else
         reg_ack_o <= acc_start;
   end

   // Read data valid with ack
   always_ff @(posedge app_clk_i) begin
      if (acc_start)
         reg_rdata_o <= rdata_mux;
   end

   // Tx byte held for the push strobe
   always_ff @(posedge app_clk_i) begin
      if (wr_ack && addr == REG_TXDATA)
         tx_data_o <= reg_wdata_i[7:0];
   end

   //////////////////////////////////////////////////
   // Control registers
   //////////////////////////////////////////////////
   always_ff @(posedge app_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         tx_en_o    <= 1'b0;
         rx_en_o    <= 1'b0;
         baud_div_o <= `SIO_DIV_RESET;
         gpio_out_o <= 2'b00;
         gpio_oe_o  <= 2'b00;
         overrun_q  <= 1'b0;
         tx_push_o  <= 1'b0;
      end else begin
         tx_push_o <= wr_ack & (addr == REG_TXDATA);  // Strobe one cycle after ack
         if (wr_ack && addr == REG_CTRL) begin
            tx_en_o <= reg_wdata_i[0];
            rx_en_o <= reg_wdata_i[1];
         end
         if (wr_ack && addr == REG_BAUD)
            baud_div_o <= reg_wdata_i[`SIO_DIV_W-1:0];
         if (wr_ack && addr == REG_GPIO_OUT) begin
            gpio_out_o <= reg_wdata_i[1:0];
            gpio_oe_o  <= reg_wdata_i[3:2];
         end
         // Set wins over a clear in the same cycle
         if (rx_drop_i)
            overrun_q <= 1'b1;
         else if (wr_ack && addr == REG_STATUS && reg_wdata_i[3])
            overrun_q <= 1'b0;  // Write 1 to clear
      end
   end

endmodule

// ==== src/serial_io_pkg.sv ====
// Shared types for the serial peripheral
// Register map, pad modes and UART FSM states
package serial_io_pkg;

   // Register map, word addresses
   typedef enum logic [3:0] {
      REG_CTRL     = 4'd0,  // bit0 tx en, bit1 rx en
      REG_BAUD     = 4'd1,  // Bit time divider
      REG_STATUS   = 4'd2,  // Fifo flags, sticky overrun
      REG_TXDATA   = 4'd3,  // Write pushes tx fifo
      REG_RXDATA   = 4'd4,  // Read pops rx fifo
      REG_GPIO_OUT = 4'd5,  // bits1:0 out, bits3:2 oe
      REG_GPIO_IN  = 4'd6   // Pad levels
   } reg_addr_e;

   // Pad owner select
   typedef enum logic [1:0] {
      PAD_UART = 2'b00,
      PAD_GPIO = 2'b01,
      PAD_OFF0 = 2'b10,  // Pads released
      PAD_OFF1 = 2'b11   // Pads released
   } pad_mode_e;

   // Transmitter FSM
   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

   // Receiver FSM
   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

// ==== src/serial_io_settings.svh ====
// Build-time settings for the shared-pin serial peripheral
// FIFO depth, baud divider width and divider reset value
`ifndef SERIAL_IO_SETTINGS_SVH
`define SERIAL_IO_SETTINGS_SVH

//////////////////////////////////////////////////
// FIFO sizing
//////////////////////////////////////////////////

// Entries per byte FIFO, same for transmit and receive
`define SIO_FIFO_DEPTH 8

//////////////////////////////////////////////////
// Baud generator
//////////////////////////////////////////////////

// Width of the divider register
`define SIO_DIV_W 16

// Divider after reset
// One bit time is divider+1 clocks
`define SIO_DIV_RESET 16'd7

`endif

// ==== src/serial_io_top.sv ====
// Shared-pin serial peripheral top level
// Register block, tx/rx FIFOs, UART and the pad mode multiplexer
`timescale 1ns/1ps
`include "serial_io_settings.svh"

module serial_io_top import serial_io_pkg::*; (
   input  logic        app_clk_i,
   input  logic        rst_n_i,
   input  logic [1:0]  pad_sel_i,     // Pad owner
   // Register bus
   input  logic        reg_cs_i,
   input  logic        reg_wr_i,
   input  logic [3:0]  reg_addr_i,
   input  logic [31:0] reg_wdata_i,
   output logic [31:0] reg_rdata_o,
   output logic        reg_ack_o,
   // Pads, RXD or GPIO0 / TXD or GPIO1
   input  logic        pad0_i,
   output logic        pad0_o,
   output logic        pad0_oen_o,    // Active low
   input  logic        pad1_i,
   output logic        pad1_o,
   output logic        pad1_oen_o     // Active low
);

   pad_mode_e             mode;
   logic [31:0]           regs_rdata;
   logic                  tx_push, tx_pop, tx_full, tx_empty;
   logic                  rx_push, rx_pop, rx_empty, rx_drop;
   logic [7:0]            tx_wdata, tx_rdata, rx_wdata, rx_rdata;
   logic                  tx_en, rx_en, txd, rxd;
   logic [`SIO_DIV_W-1:0] baud_div;
   logic [1:0]            gpio_out, gpio_oe;
   logic [1:0]            gpio_meta_q, gpio_in_q;  // Pad input sync

   assign mode = pad_mode_e'(pad_sel_i);

   // Ack always passes, data only from an active mode
   assign reg_rdata_o = (mode == PAD_UART || mode == PAD_GPIO) ? regs_rdata : 32'h0;

   assign rxd = (mode == PAD_UART) ? pad0_i : 1'b1;  // Idle line otherwise

   //////////////////////////////////////////////////
   // Pad mode multiplexer
   //////////////////////////////////////////////////
   always_comb begin
      case (mode)
         PAD_UART: {pad1_o, pad1_oen_o, pad0_o, pad0_oen_o} = {txd, 1'b0, 1'b1, 1'b1};
         PAD_GPIO: {pad1_o, pad1_oen_o, pad0_o, pad0_oen_o} =
                      {gpio_out[1], ~gpio_oe[1], gpio_out[0], ~gpio_oe[0]};
         default:  {pad1_o, pad1_oen_o, pad0_o, pad0_oen_o} = 4'b1111;  // Released
      endcase
   end

   // GPIO input path, two flops
   always_ff @(posedge app_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         gpio_meta_q <= 2'b00;
         gpio_in_q   <= 2'b00;
      end else begin
         gpio_meta_q <= (mode == PAD_GPIO) ? {pad1_i, pad0_i} : 2'b00;
         gpio_in_q   <= gpio_meta_q;
      end
   end

   periph_regs u_regs (
      .app_clk_i(app_clk_i), .rst_n_i(rst_n_i),
      .reg_cs_i(reg_cs_i), .reg_wr_i(reg_wr_i), .reg_addr_i(reg_addr_i),
      .reg_wdata_i(reg_wdata_i), .reg_rdata_o(regs_rdata), .reg_ack_o(reg_ack_o),
      .tx_push_o(tx_push), .tx_data_o(tx_wdata), .tx_full_i(tx_full), .tx_empty_i(tx_empty),
      .rx_pop_o(rx_pop), .rx_data_i(rx_rdata), .rx_empty_i(rx_empty), .rx_drop_i(rx_drop),
      .tx_en_o(tx_en), .rx_en_o(rx_en), .baud_div_o(baud_div),
      .gpio_out_o(gpio_out), .gpio_oe_o(gpio_oe), .gpio_in_i(gpio_in_q)
   );

   byte_fifo #(.DEPTH(`SIO_FIFO_DEPTH)) u_tx_fifo (
      .app_clk_i(app_clk_i), .rst_n_i(rst_n_i),
      .push_i(tx_push), .wr_data_i(tx_wdata), .pop_i(tx_pop), .rd_data_o(tx_rdata),
      .full_o(tx_full), .empty_o(tx_empty), .drop_o()  // Dropped bytes not reported
   );

   byte_fifo #(.DEPTH(`SIO_FIFO_DEPTH)) u_rx_fifo (
      .app_clk_i(app_clk_i), .rst_n_i(rst_n_i),
      .push_i(rx_push), .wr_data_i(rx_wdata), .pop_i(rx_pop), .rd_data_o(rx_rdata),
      .full_o(), .empty_o(rx_empty), .drop_o(rx_drop)  // Drop feeds overrun
   );

   uart_tx u_uart_tx (
      .app_clk_i(app_clk_i), .rst_n_i(rst_n_i), .tx_en_i(tx_en), .baud_div_i(baud_div),
      .fifo_data_i(tx_rdata), .fifo_empty_i(tx_empty), .fifo_pop_o(tx_pop), .txd_o(txd)
   );

   uart_rx u_uart_rx (
      .app_clk_i(app_clk_i), .rst_n_i(rst_n_i), .rx_en_i(rx_en), .baud_div_i(baud_div),
      .rxd_i(rxd), .fifo_push_o(rx_push), .fifo_data_o(rx_wdata)
   );

endmodule

// ==== src/uart_rx.sv ====
// UART receiver, 8N1, LSB first
// Synchronizer, half-bit start check, mid-bit sampling, stop-bit check
`timescale 1ns/1ps
`include "serial_io_settings.svh"

module uart_rx import serial_io_pkg::*; (
   input  logic                  app_clk_i,
   input  logic                  rst_n_i,
   input  logic                  rx_en_i,
   input  logic [`SIO_DIV_W-1:0] baud_div_i,   // Bit time minus one
   input  logic                  rxd_i,        // Async line
   output logic                  fifo_push_o,  // One per good frame
   output logic [7:0]            fifo_data_o
);

   rx_state_e             state_q;
   logic [1:0]            sync_q;       // Double flop
   logic                  rxd_prev_q;   // For edge detect
   logic                  rxd_s;
   logic [`SIO_DIV_W-1:0] bit_cnt_q;
   logic [2:0]            bit_idx_q;
   logic [7:0]            shift_q;
   logic                  sample_pt;    // Current bit is sampled here
   logic                  fall;

   assign rxd_s = sync_q[1];
   assign fall  = rxd_prev_q & ~rxd_s;

   // Half a bit into the start bit, then a full bit per sample
   assign sample_pt = (state_q == RX_START) ? (bit_cnt_q == (baud_div_i >> 1))
                                            : (bit_cnt_q == baud_div_i);

   assign fifo_data_o = shift_q;  // Stable in idle while push is high

   //////////////////////////////////////////////////
   // Input synchronizer
   //////////////////////////////////////////////////
   always_ff @(posedge app_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         sync_q     <= 2'b11;
         rxd_prev_q <= 1'b1;
      end else begin
         sync_q     <= {sync_q[0], rxd_i};
         rxd_prev_q <= rxd_s;
      end
   end

   // Data bits enter at the top, LSB first
   always_ff @(posedge app_clk_i) begin
      if (state_q == RX_DATA && sample_pt)
         shift_q <= {rxd_s, shift_q[7:1]};
   end

   //////////////////////////////////////////////////
   // Frame FSM
   //////////////////////////////////////////////////
   always_ff @(posedge app_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q     <= RX_IDLE;
         bit_cnt_q   <= '0;
         bit_idx_q   <= '0;
         fifo_push_o <= 1'b0;
      end else begin
         fifo_push_o <= 1'b0;
         bit_cnt_q   <= (state_q == RX_IDLE || sample_pt) ? '0 : bit_cnt_q + 1'b1;
         case (state_q)
            RX_IDLE: begin
               if (rx_en_i && fall)
                  state_q <= RX_START;
            end
            RX_START: begin
               if (sample_pt) begin
                  bit_idx_q <= '0;
                  // Line back high at half bit is a glitch
                  state_q   <= rxd_s ? RX_IDLE : RX_DATA;
               end
            end
            RX_DATA: begin
               if (sample_pt) begin
                  bit_idx_q <= bit_idx_q + 1'b1;
                  if (bit_idx_q == 3'd7)
                     state_q <= RX_STOP;
               end
            end
            RX_STOP: begin
               if (sample_pt) begin
                  state_q     <= RX_IDLE;
                  fifo_push_o <= rxd_s;  // Framing error drops the byte
               end
            end
            default: state_q <= RX_IDLE;
         endcase
      end
   end

endmodule

// ==== src/uart_tx.sv ====
// UART transmitter, 8N1, LSB first
// Pops the transmit FIFO and serializes start, data and stop bits
`timescale 1ns/1ps
`include "serial_io_settings.svh"

module uart_tx import serial_io_pkg::*; (
   input  logic                  app_clk_i,
   input  logic                  rst_n_i,
   input  logic                  tx_en_i,
   input  logic [`SIO_DIV_W-1:0] baud_div_i,   // Bit time minus one
   input  logic [7:0]            fifo_data_i,
   input  logic                  fifo_empty_i,
   output logic                  fifo_pop_o,
   output logic                  txd_o          // Idles high
);

   tx_state_e             state_q;
   logic [`SIO_DIV_W-1:0] bit_cnt_q;
   logic [2:0]            bit_idx_q;    // Data bit number
   logic [7:0]            shift_q;
   logic                  bit_end;
   logic                  can_load;

   assign bit_end  = (bit_cnt_q == baud_div_i);
   assign can_load = tx_en_i & ~fifo_empty_i;

   // Load from idle, or straight after a stop bit for back-to-back bytes
   always_comb begin
      case (state_q)
         TX_IDLE: fifo_pop_o = can_load;
         TX_STOP: fifo_pop_o = can_load & bit_end;
         default: fifo_pop_o = 1'b0;
      endcase
   end

   // Shift register, bit 0 is next out
   always_ff @(posedge app_clk_i) begin
      if (fifo_pop_o)
         shift_q <= fifo_data_i;
      else if (bit_end && (state_q == TX_START || state_q == TX_DATA))
         shift_q <= {1'b0, shift_q[7:1]};
   end

   always_ff @(posedge app_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q   <= TX_IDLE;
         bit_cnt_q <= '0;
         bit_idx_q <= '0;
         txd_o     <= 1'b1;
      end else begin
         bit_cnt_q <= (state_q == TX_IDLE || bit_end) ? '0 : bit_cnt_q + 1'b1;
         if (fifo_pop_o) begin
            state_q <= TX_START;
            txd_o   <= 1'b0;  // Start bit
         end else if (bit_end) begin
            case (state_q)
               TX_START: begin
                  state_q   <= TX_DATA;
                  bit_idx_q <= '0;
                  txd_o     <= shift_q[0];
               end
               TX_DATA: begin
                  bit_idx_q <= bit_idx_q + 1'b1;
                  if (bit_idx_q == 3'd7) begin
                     state_q <= TX_STOP;
                     txd_o   <= 1'b1;  // Stop bit
                  end else begin
                     txd_o <= shift_q[0];
                  end
               end
               TX_STOP: state_q <= TX_IDLE;  // Nothing queued
               default: state_q <= TX_IDLE;
            endcase
         end
      end
   end

endmodule

// ==== testbench/tb_serial_io.sv ====
// Testbench for the shared-pin serial peripheral
// Bus tasks, UART line monitor and driver, LFSR data, assertion checks
`timescale 1ns/1ps
`include "serial_io_settings.svh"

module tb_serial_io import serial_io_pkg::*; ();

   localparam int ACK_LIMIT  = 16;    // Clocks to wait for an ack
   localparam int WAIT_LIMIT = 4000;  // Clocks to wait for line activity
   localparam int POLL_LIMIT = 100;   // Status reads before giving up

   logic        app_clk;
   logic        rst_n;
   logic [1:0]  pad_sel;
   logic        reg_cs, reg_wr;
   logic [3:0]  reg_addr;
   logic [31:0] reg_wdata;
   logic [31:0] reg_rdata_o;
   logic        reg_ack_o;
   logic        pad0_o, pad0_oen_o, pad1_o, pad1_oen_o;
   logic        pad1_in;
   logic        line_val;            // Line driver level
   logic        loopback;            // pad0 follows pad1
   logic        lb_q;
   logic        pad0_w;

   int          cur_div;             // Divider the line models use
   int          err_cnt, err_mark, ok_tests, bad_tests;
   string       test_name;
   logic [31:0] lfsr_q;
   logic [7:0]  tx_seen [$];         // Bytes decoded on pad1
   logic [7:0]  sent [$];            // Bytes expected back
   event        stall_ev;

   // Loopback copy taken on the falling edge
   always @(negedge app_clk) lb_q <= pad1_o;
   assign pad0_w = loopback ? lb_q : line_val;

   serial_io_top UUT (
      .app_clk_i(app_clk), .rst_n_i(rst_n), .pad_sel_i(pad_sel),
      .reg_cs_i(reg_cs), .reg_wr_i(reg_wr), .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata),
      .reg_rdata_o(reg_rdata_o), .reg_ack_o(reg_ack_o),
      .pad0_i(pad0_w), .pad0_o(pad0_o), .pad0_oen_o(pad0_oen_o),
      .pad1_i(pad1_in), .pad1_o(pad1_o), .pad1_oen_o(pad1_oen_o)
   );

   initial begin
      app_clk = 1'b0;
      forever #50 app_clk = ~app_clk;  // 100 ns period
   end

   //////////////////////////////////////////////////
   // Concurrent checks
   //////////////////////////////////////////////////
   ack_single: assert property (@(posedge app_clk) disable iff (!rst_n)
         reg_ack_o |=> !reg_ack_o)
      else begin
         $display("error: reg_ack_o stayed high for more than one cycle");
         err_cnt++;
      end

   // UART mode drives pad1 and listens on pad0
   uart_pads: assert property (@(posedge app_clk) disable iff (!rst_n)
         (pad_sel == PAD_UART) |-> (!pad1_oen_o && pad0_oen_o))
      else begin
         $display("error: pad enables wrong in UART mode");
         err_cnt++;
      end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////
   task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
         else begin
            $display("MISMATCH %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
            err_cnt++;
         end
   endtask

   task automatic give_up(input string why);
      $display("error: %s in test %s", why, test_name);
      -> stall_ev;
      forever @(negedge app_clk);  // Watchdog ends the run
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      err_mark  = err_cnt;
   endtask

   task automatic end_test();
      if (err_cnt == err_mark) begin
         ok_tests++;
         $display("test %s: ok", test_name);
      end else begin
         bad_tests++;
         $display("test %s: FAILED with %0d errors", test_name, err_cnt - err_mark);
      end
   endtask

   // Galois LFSR with taps x^32+x^22+x^2+x+1
   function automatic logic next_bit();
      logic b;
      b      = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (b)
         lfsr_q = lfsr_q ^ 32'h8020_0003;
      return b;
   endfunction

   function automatic logic [7:0] rand_byte();
      logic [7:0] v;
      for (int i = 0; i < 8; i++)
         v[i] = next_bit();  // One step per bit
      return v;
   endfunction

   // Bus access from a falling edge with cs held through the ack cycle
   task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
      int n;
      n         = 0;
      reg_cs    = 1'b1;
      reg_wr    = 1'b1;
      reg_addr  = addr;
      reg_wdata = data;
      @(negedge app_clk);
      while (!reg_ack_o) begin
         if (n == ACK_LIMIT)
            give_up("no ack on a register write");
         n++;
         @(negedge app_clk);
      end
      @(negedge app_clk);
      reg_cs = 1'b0;
      reg_wr = 1'b0;
      @(negedge app_clk);  // Idle cycle between accesses
   endtask

   task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
      int n;
      n        = 0;
      reg_cs   = 1'b1;
      reg_wr   = 1'b0;
      reg_addr = addr;
      @(negedge app_clk);
      while (!reg_ack_o) begin
         if (n == ACK_LIMIT)
            give_up("no ack on a register read");
         n++;
         @(negedge app_clk);
      end
      data = reg_rdata_o;  // Valid with ack
      @(negedge app_clk);
      reg_cs = 1'b0;
      @(negedge app_clk);
   endtask

   task automatic set_divider(input int d);
      write_reg(REG_BAUD, d);
      cur_div = d;
   endtask

   task automatic wait_tx_bytes(input int count);
      int n;
      n = 0;
      while (tx_seen.size() < count) begin
         if (n == WAIT_LIMIT)
            give_up("too few frames on pad1");
         n++;
         @(negedge app_clk);
      end
   endtask

   // Poll until the receive FIFO holds a byte
   task automatic wait_rx_ready();
      logic [31:0] st;
      int          n;
      n = 0;
      read_reg(REG_STATUS, st);
      while (st[2]) begin
         if (n == POLL_LIMIT)
            give_up("receive FIFO stayed empty");
         n++;
         read_reg(REG_STATUS, st);
      end
   endtask

   // 8N1 frame on pad0 with a selectable stop level
   task automatic send_frame(input logic [7:0] data, input logic stop_bit);
      line_val = 1'b0;
      repeat (cur_div + 1) @(negedge app_clk);
      for (int i = 0; i < 8; i++) begin
         line_val = data[i];
         repeat (cur_div + 1) @(negedge app_clk);
      end
      line_val = stop_bit;
      repeat (cur_div + 1) @(negedge app_clk);
      line_val = 1'b1;
      repeat (2 * (cur_div + 1)) @(negedge app_clk);  // Two idle bits
   endtask

   //////////////////////////////////////////////////
   // Line monitor on pad1
   //////////////////////////////////////////////////
   initial begin : line_monitor
      logic       prev;
      logic [7:0] b;
      prev = 1'b1;
      forever begin
         @(negedge app_clk);
         if (pad_sel != PAD_UART)
            prev = 1'b1;
         else if (prev && !pad1_o) begin
            repeat ((cur_div + 1) / 2) @(negedge app_clk);  // Mid start bit
            assert (!pad1_o) else begin
               $display("error: start bit on pad1 shorter than half a bit");
               err_cnt++;
            end
            for (int i = 0; i < 8; i++) begin
               repeat (cur_div + 1) @(negedge app_clk);
               b[i] = pad1_o;  // LSB first
            end
            repeat (cur_div + 1) @(negedge app_clk);
            assert (pad1_o) else begin
               $display("error: frame on pad1 has a low stop bit");
               err_cnt++;
            end
            tx_seen.push_back(b);
            prev = 1'b1;
         end else
            prev = pad1_o;
      end
   end

   initial begin : watchdog
      @(stall_ev);
      $display("tests failed");
      $finish;
   end

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////
   initial begin : run_tests
      logic [31:0] rd;
      logic [7:0]  b;
      rst_n     = 1'b0;
      pad_sel   = PAD_UART;
      reg_cs    = 1'b0;
      reg_wr    = 1'b0;
      reg_addr  = 4'h0;
      reg_wdata = 32'h0;
      pad1_in   = 1'b0;
      line_val  = 1'b1;  // Idle line
      loopback  = 1'b0;
      lfsr_q    = 32'h3b99_6cfa;
      cur_div   = `SIO_DIV_RESET;
      err_cnt   = 0;
      ok_tests  = 0;
      bad_tests = 0;
      repeat (16) @(negedge app_clk);
      rst_n = 1'b1;
      @(negedge app_clk);

      begin_test("reset");
      check_eq("pad1 out, pad1 oen, pad0 oen", 3'b101, {pad1_o, pad1_oen_o, pad0_oen_o});
      read_reg(REG_CTRL, rd);
      check_eq("ctrl", 32'h0, rd);
      read_reg(REG_BAUD, rd);
      check_eq("baud", 32'(`SIO_DIV_RESET), rd);
      read_reg(REG_STATUS, rd);
      check_eq("status", {28'h0, 1'b0, 1'b1, 1'b1, 1'b0}, rd);  // Both FIFOs empty
      end_test();

      begin_test("transmit");
      set_divider(3);
      write_reg(REG_CTRL, 32'h1);
      sent.delete();
      tx_seen.delete();
      repeat (4) begin
         b = rand_byte();
         sent.push_back(b);
         write_reg(REG_TXDATA, {24'h0, b});
      end
      wait_tx_bytes(4);
      for (int i = 0; i < 4; i++)
         check_eq($sformatf("byte %0d", i), sent[i], tx_seen[i]);
      end_test();

      begin_test("full_drop");
      write_reg(REG_CTRL, 32'h0);
      sent.delete();
      tx_seen.delete();
      for (int i = 0; i <= `SIO_FIFO_DEPTH; i++) begin
         b = rand_byte();
         if (i < `SIO_FIFO_DEPTH)
            sent.push_back(b);  // Last write has no room
         write_reg(REG_TXDATA, {24'h0, b});
      end
      read_reg(REG_STATUS, rd);
      check_eq("status", {28'h0, 1'b0, 1'b1, 1'b0, 1'b1}, rd);  // tx full
      write_reg(REG_CTRL, 32'h1);
      wait_tx_bytes(`SIO_FIFO_DEPTH);
      repeat (20 * (cur_div + 1)) @(negedge app_clk);  // Two frame times of silence
      check_eq("frame count", `SIO_FIFO_DEPTH, tx_seen.size());
      for (int i = 0; i < `SIO_FIFO_DEPTH; i++)
         check_eq($sformatf("byte %0d", i), sent[i], tx_seen[i]);
      end_test();

      begin_test("loopback");
      loopback = 1'b1;
      write_reg(REG_CTRL, 32'h3);
      sent.delete();
      repeat (4) begin
         b = rand_byte();
         sent.push_back(b);
         write_reg(REG_TXDATA, {24'h0, b});
      end
      for (int i = 0; i < 4; i++) begin
         wait_rx_ready();
         read_reg(REG_RXDATA, rd);
         check_eq($sformatf("rx byte %0d", i), {24'h0, sent[i]}, rd);
      end
      loopback = 1'b0;
      end_test();

      begin_test("bad_stop");
      send_frame(rand_byte(), 1'b0);
      read_reg(REG_STATUS, rd);
      check_eq("status", {28'h0, 1'b0, 1'b1, 1'b1, 1'b0}, rd);  // Frame dropped
      b = rand_byte();
      send_frame(b, 1'b1);
      wait_rx_ready();
      read_reg(REG_RXDATA, rd);
      check_eq("next good byte", {24'h0, b}, rd);
      end_test();

      begin_test("overrun");
      sent.delete();
      for (int i = 0; i <= `SIO_FIFO_DEPTH; i++) begin
         b = rand_byte();
         sent.push_back(b);
         send_frame(b, 1'b1);
      end
      read_reg(REG_STATUS, rd);
      check_eq("status set", {28'h0, 1'b1, 1'b0, 1'b1, 1'b0}, rd);
      write_reg(REG_STATUS, 32'h8);  // Clear overrun
      read_reg(REG_STATUS, rd);
      check_eq("status cleared", {28'h0, 1'b0, 1'b0, 1'b1, 1'b0}, rd);
      for (int i = 0; i < `SIO_FIFO_DEPTH; i++) begin
         read_reg(REG_RXDATA, rd);
         check_eq($sformatf("rx byte %0d", i), {24'h0, sent[i]}, rd);
      end
      end_test();

      begin_test("gpio");
      pad_sel = PAD_GPIO;
      write_reg(REG_GPIO_OUT, 32'h9);  // oe 10, out 01
      // pad1 driven low, pad0 released
      check_eq("pads", 4'b0011, {pad1_o, pad1_oen_o, pad0_o, pad0_oen_o});
      write_reg(REG_GPIO_OUT, 32'h6);  // oe 01, out 10
      // pad1 released, pad0 driven low
      check_eq("pads", 4'b1100, {pad1_o, pad1_oen_o, pad0_o, pad0_oen_o});
      pad1_in  = 1'b1;
      line_val = 1'b0;
      repeat (3) @(negedge app_clk);  // Two-flop pad synchronizer
      read_reg(REG_GPIO_IN, rd);
      check_eq("gpio in 10", 32'h2, rd);
      pad1_in  = 1'b0;
      line_val = 1'b1;
      repeat (3) @(negedge app_clk);
      read_reg(REG_GPIO_IN, rd);
      check_eq("gpio in 01", 32'h1, rd);
      end_test();

      begin_test("pads_off");
      write_reg(REG_CTRL, 32'h3);
      for (int m = 2; m < 4; m++) begin
         pad_sel = m[1:0];
         @(negedge app_clk);  // New mode reaches the pads
         check_eq($sformatf("pads mode %0d", m), 4'hf,
                  {pad1_o, pad1_oen_o, pad0_o, pad0_oen_o});
         read_reg(REG_CTRL, rd);
         check_eq($sformatf("ctrl mode %0d", m), 32'h0, rd);
      end
      end_test();

      $display("%0d tests run, %0d ok, %0d not ok, %0d check errors",
               ok_tests + bad_tests, ok_tests, bad_tests, err_cnt);
      if (bad_tests == 0 && err_cnt == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule
